//--- hdl/motion_consts.svh
`ifndef MOTION_CONSTS_SVH
`define MOTION_CONSTS_SVH

// Move buffer geometry, depth is also the credit count after reset
`define MOVE_BUFFER_DEPTH 4
`define MOVE_BUFFER_BITS 2

// CLK cycles per DDA tick, minus one
`define CLK_DIVISOR_DEFAULT 8'd3

// Header codes in the top byte of a word
`define CMD_COORDINATED_STEP 8'h01
`define CMD_MOTOR_ENABLE 8'h0a
`define CMD_CLK_DIVISOR 8'h0b
`define CMD_API_VERSION 8'hfe

// Reply bytes for the version command
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd3
`define VERSION_PATCH 8'd1

`endif

//--- hdl/host_pkg.sv
`default_nettype none

// Host side of the link: SPI words and how the decoder reads them
package host_pkg;

  typedef logic [63:0] spi_word_t;

  // Header view of a received word
  typedef struct packed {
    logic [7:0]  code;     // Command byte, MSB of the word
    logic [54:0] payload;
    logic        arg0;     // Move direction or enable value
  } cmd_header_t;

  // Position inside a multi-word command
  typedef enum logic [1:0] {
    header,
    duration,
    increment,
    accel
  } decode_state_t;

endpackage

`default_nettype wire

//--- hdl/motion_pkg.sv
`default_nettype none

// Motion side: queued segments and position values
package motion_pkg;

  // One coordinated move as stored in the move buffer
  typedef struct packed {
    logic               dir;
    logic        [63:0] duration;             // DDA ticks
    logic signed [63:0] increment;            // Added to the accumulator per tick
    logic signed [63:0] increment_increment;  // Acceleration term
  } move_seg_t;

  // Encoder position, 4x counts
  typedef logic signed [63:0] enc_count_t;

endpackage

`default_nettype wire

//--- hdl/spi_word_rx.sv
`timescale 1ns/10ps
`default_nettype none

module spi_word_rx (
  input  wire logic                CLK,
  input  wire logic                resetn,
  input  wire logic                sck,
  input  wire logic                cs,
  input  wire logic                copi,
  output logic                     cipo,
  input  wire host_pkg::spi_word_t tx_word,
  output host_pkg::spi_word_t      rx_word,
  output logic                     rx_valid
);

  logic [2:0]          sck_q;   // Two sync stages plus one for edge detect
  logic [2:0]          cs_q;
  logic [1:0]          copi_q;
  logic                sck_rise;
  logic                sck_fall;
  logic                cs_fall;
  logic                cs_idle;
  logic [5:0]          bit_cnt;
  logic                last_bit;
  host_pkg::spi_word_t rx_shift;
  host_pkg::spi_word_t tx_shift;
  host_pkg::spi_word_t rx_swapped;
  host_pkg::spi_word_t tx_swapped;

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_fall  = ~cs_q[1] & cs_q[2];
  assign cs_idle  = cs_q[1];    // CS is active low

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sck_q  <= 3'b000;
      cs_q   <= 3'b111;
      copi_q <= 2'b00;
    end else begin
      sck_q  <= {sck_q[1:0], sck};
      cs_q   <= {cs_q[1:0], cs};
      copi_q <= {copi_q[0], copi};
    end
  end

  // Least significant byte travels first, each byte MSB first
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      rx_swapped[8*i +: 8]     = rx_shift[8*(7-i) +: 8];
      tx_swapped[8*(7-i) +: 8] = tx_word[8*i +: 8];
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      bit_cnt  <= '0;
      last_bit <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      last_bit <= 1'b0;
      rx_valid <= last_bit;
      if (cs_idle) begin
        bit_cnt <= '0;                // Deselect restarts framing
      end else if (sck_rise) begin
        bit_cnt  <= bit_cnt + 6'd1;
        last_bit <= (bit_cnt == 6'd63);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (sck_rise && !cs_idle) begin
      rx_shift <= {rx_shift[62:0], copi_q[1]};
    end
    if (last_bit) begin
      rx_word <= rx_swapped;
    end
  end

  // Reply word is captured as the host selects us
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      tx_shift <= tx_swapped;
    end else if (sck_fall && !cs_idle) begin
      tx_shift <= {tx_shift[62:0], 1'b0};
    end
  end

  assign cipo = tx_shift[63];

endmodule

`default_nettype wire

//--- hdl/command_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "motion_consts.svh"

module command_decoder (
  input  wire logic                   CLK,
  input  wire logic                   resetn,
  input  wire logic                   halt,
  input  wire host_pkg::spi_word_t    rx_word,
  input  wire logic                   rx_valid,
  output host_pkg::spi_word_t         tx_word,
  input  wire motion_pkg::enc_count_t enc_count,
  output logic                        push,
  output motion_pkg::move_seg_t       push_seg,
  input  wire logic                   credit_return,
  output logic                        buffer_ready,
  output logic                        enable,
  output logic [7:0]                  clock_divisor
);

  host_pkg::decode_state_t    state;
  host_pkg::cmd_header_t      hdr;
  motion_pkg::enc_count_t     enc_snap;   // Position at the move header
  logic                       move_ok;    // A credit was free at the header
  logic [`MOVE_BUFFER_BITS:0] credits;

  assign hdr          = rx_word;
  assign buffer_ready = (credits != '0);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state         <= host_pkg::header;
      tx_word       <= '0;
      push          <= 1'b0;
      move_ok       <= 1'b0;
      enable        <= 1'b0;
      clock_divisor <= `CLK_DIVISOR_DEFAULT;
    end else begin
      push <= 1'b0;
      if (rx_valid) begin
        tx_word <= '0;                  // Zero reply unless set below
        case (state)
          host_pkg::header: begin
            case (hdr.code)
              `CMD_COORDINATED_STEP: begin
                state   <= host_pkg::duration;
                move_ok <= buffer_ready;  // No credit drops the move
              end
              `CMD_MOTOR_ENABLE: enable <= hdr.arg0;
              `CMD_CLK_DIVISOR: clock_divisor <= {hdr.payload[6:0], hdr.arg0};
              `CMD_API_VERSION: begin
                tx_word <= {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
              end
              default: ;
            endcase
          end
          host_pkg::duration: begin
            state   <= host_pkg::increment;
            tx_word <= enc_snap;          // Goes out during the increment word
          end
          host_pkg::increment: state <= host_pkg::accel;
          default: begin
            state <= host_pkg::header;
            push  <= move_ok;
          end
        endcase
      end
    end
  end

  // Segment assembly, fields are valid once push rises
  always_ff @(posedge CLK) begin
    if (rx_valid) begin
      case (state)
        host_pkg::header: begin
          if (hdr.code == `CMD_COORDINATED_STEP) begin
            push_seg.dir <= hdr.arg0;
            enc_snap     <= enc_count;
          end
        end
        host_pkg::duration: push_seg.duration <= rx_word;
        host_pkg::increment: push_seg.increment <= rx_word;
        default: push_seg.increment_increment <= rx_word;
      endcase
    end
  end

  // One credit per free buffer slot
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      credits <= `MOVE_BUFFER_DEPTH;
    end else if (halt) begin
      credits <= `MOVE_BUFFER_DEPTH;  // Buffer was flushed
    end else begin
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hdl/move_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "motion_consts.svh"

module move_buffer (
  input  wire logic                  CLK,
  input  wire logic                  resetn,
  input  wire logic                  halt,
  input  wire logic                  push,
  input  wire motion_pkg::move_seg_t push_seg,
  input  wire logic                  pop,
  output logic                       seg_avail,
  output motion_pkg::move_seg_t      head_seg,
  output logic                       credit_return
);

  localparam int DEPTH = `MOVE_BUFFER_DEPTH;

  motion_pkg::move_seg_t      slots [DEPTH];
  logic [`MOVE_BUFFER_BITS:0] wr_idx;  // Top bit tells full from empty
  logic [`MOVE_BUFFER_BITS:0] rd_idx;
  logic                       do_push;
  logic                       do_pop;

  assign seg_avail = (rd_idx != wr_idx);
  assign head_seg  = slots[rd_idx[`MOVE_BUFFER_BITS-1:0]];
  assign do_push   = push & ~halt;
  assign do_pop    = pop & seg_avail & ~halt;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_idx        <= '0;
      rd_idx        <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= do_pop;
      if (halt) begin
        rd_idx <= wr_idx;   // Drop everything queued
      end else begin
        if (do_push) wr_idx <= wr_idx + 1'b1;
        if (do_pop) rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      slots[wr_idx[`MOVE_BUFFER_BITS-1:0]] <= push_seg;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dda_step_gen.sv
`timescale 1ns/10ps
`default_nettype none

module dda_step_gen (
  input  wire logic                  CLK,
  input  wire logic                  resetn,
  input  wire logic                  halt,
  input  wire logic                  seg_avail,
  input  wire motion_pkg::move_seg_t head_seg,
  input  wire logic [7:0]            clock_divisor,
  output logic                       pop,
  output logic                       step,
  output logic                       dir,
  output logic                       move_done
);

  localparam logic signed [63:0] STEP_THRESHOLD = 64'sh1_0000_0000;

  logic               busy;
  logic [7:0]         clk_cnt;     // CLK cycles left to the next tick
  logic [63:0]        tick_cnt;    // Ticks left in the segment
  logic signed [63:0] increment;
  logic signed [63:0] increment_increment;
  logic signed [63:0] accum;
  logic signed [63:0] accum_sum;
  logic               seg_dir;
  logic               tick;
  logic               finishing;

  assign tick      = busy & (clk_cnt == 8'd0);
  assign finishing = tick & (tick_cnt <= 64'd1);  // Zero duration runs one tick
  assign accum_sum = accum + increment;

  // Next segment is taken on the same edge the current one ends
  assign pop = seg_avail & ~halt & (~busy | finishing);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      busy      <= 1'b0;
      clk_cnt   <= '0;
      accum     <= '0;
      seg_dir   <= 1'b0;
      step      <= 1'b0;
      dir       <= 1'b0;
      move_done <= 1'b0;
    end else begin
      step <= 1'b0;
      dir  <= seg_dir;        // Delayed to line up with step
      if (halt) begin
        busy  <= 1'b0;
        accum <= '0;
      end else begin
        if (busy) begin
          clk_cnt <= tick ? clock_divisor : clk_cnt - 8'd1;
        end
        if (tick) begin
          if (accum_sum >= STEP_THRESHOLD) begin
            accum <= accum_sum - STEP_THRESHOLD;
            step  <= 1'b1;
          end else begin
            accum <= accum_sum;
          end
        end
        if (finishing) begin
          busy      <= 1'b0;
          move_done <= ~move_done;
        end
        if (pop) begin
          busy    <= 1'b1;
          clk_cnt <= clock_divisor;
          seg_dir <= head_seg.dir;
        end
      end
    end
  end

  // Velocity and tick count of the running segment
  always_ff @(posedge CLK) begin
    if (pop) begin
      tick_cnt            <= head_seg.duration;
      increment           <= head_seg.increment;
      increment_increment <= head_seg.increment_increment;
    end else if (tick) begin
      tick_cnt  <= tick_cnt - 64'd1;
      increment <= increment + increment_increment;
    end
  end

endmodule

`default_nettype wire

//--- hdl/quad_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module quad_encoder (
  input  wire logic              CLK,
  input  wire logic              resetn,
  input  wire logic              enc_a,
  input  wire logic              enc_b,
  output motion_pkg::enc_count_t count,
  output logic                   fault
);

  logic [2:0] a_q;    // Two sync stages plus previous value
  logic [2:0] b_q;
  logic       a_chg;
  logic       b_chg;
  logic       same;
  logic       count_up;
  logic       count_down;

  assign a_chg = a_q[1] ^ a_q[2];
  assign b_chg = b_q[1] ^ b_q[2];
  assign same  = ~(a_q[1] ^ b_q[1]);

  // A leading B gives 00 10 11 01
  assign count_up   = (a_chg & ~b_chg & ~same) | (b_chg & ~a_chg & same);
  assign count_down = (a_chg & ~b_chg & same) | (b_chg & ~a_chg & ~same);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      a_q   <= '0;
      b_q   <= '0;
      count <= '0;
      fault <= 1'b0;
    end else begin
      a_q <= {a_q[1:0], enc_a};
      b_q <= {b_q[1:0], enc_b};
      if (count_up) begin
        count <= count + 64'sd1;
      end else if (count_down) begin
        count <= count - 64'sd1;
      end
      if (a_chg && b_chg) begin
        fault <= 1'b1;      // Lost a state, held until reset
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/motion_top.sv
`timescale 1ns/10ps
`default_nettype none

module motion_top (
  input  wire logic CLK,
  input  wire logic resetn,
  input  wire logic SCK,
  input  wire logic CS,
  input  wire logic COPI,
  output logic      CIPO,
  input  wire logic ENC_A,
  input  wire logic ENC_B,
  input  wire logic HALTN,
  output logic      STEP,
  output logic      DIR,
  output logic      ENABLE,
  output logic      MOVE_DONE,
  output logic      BUFFER_READY,
  output logic      ENC_FAULT
);

  host_pkg::spi_word_t    rx_word;
  host_pkg::spi_word_t    tx_word;
  logic                   rx_valid;
  motion_pkg::enc_count_t enc_count;
  motion_pkg::move_seg_t  push_seg;
  motion_pkg::move_seg_t  head_seg;
  logic                   push;
  logic                   pop;
  logic                   seg_avail;
  logic                   credit_return;
  logic [7:0]             clock_divisor;
  logic [1:0]             haltn_q;
  logic                   halt;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      haltn_q <= 2'b11;
    end else begin
      haltn_q <= {haltn_q[0], HALTN};
    end
  end

  assign halt = ~haltn_q[1];

  spi_word_rx u_spi (
    .CLK(CLK), .resetn(resetn),
    .sck(SCK), .cs(CS), .copi(COPI), .cipo(CIPO),
    .tx_word(tx_word), .rx_word(rx_word), .rx_valid(rx_valid)
  );

  command_decoder u_decoder (
    .CLK(CLK), .resetn(resetn), .halt(halt),
    .rx_word(rx_word), .rx_valid(rx_valid), .tx_word(tx_word),
    .enc_count(enc_count),
    .push(push), .push_seg(push_seg), .credit_return(credit_return),
    .buffer_ready(BUFFER_READY), .enable(ENABLE), .clock_divisor(clock_divisor)
  );

  move_buffer u_buffer (
    .CLK(CLK), .resetn(resetn), .halt(halt),
    .push(push), .push_seg(push_seg), .pop(pop),
    .seg_avail(seg_avail), .head_seg(head_seg), .credit_return(credit_return)
  );

  dda_step_gen u_stepgen (
    .CLK(CLK), .resetn(resetn), .halt(halt),
    .seg_avail(seg_avail), .head_seg(head_seg), .clock_divisor(clock_divisor),
    .pop(pop), .step(STEP), .dir(DIR), .move_done(MOVE_DONE)
  );

  quad_encoder u_encoder (
    .CLK(CLK), .resetn(resetn),
    .enc_a(ENC_A), .enc_b(ENC_B),
    .count(enc_count), .fault(ENC_FAULT)
  );

endmodule

`default_nettype wire

//--- tb/motion_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "motion_consts.svh"

module motion_tb;

  localparam int HALF_SCK = 5;                          // CLK cycles per SCK half period
  localparam logic signed [63:0] THRESHOLD = 64'sh1_0000_0000;

  logic CLK = 1'b0;
  logic resetn, SCK, CS, COPI, ENC_A, ENC_B, HALTN;
  logic CIPO, STEP, DIR, ENABLE, MOVE_DONE, BUFFER_READY, ENC_FAULT;

  int          mismatch_cnt = 0;
  int          other_cnt = 0;
  bit          mon_off = 1'b0;
  bit          fault_allowed = 1'b0;
  logic        prev_done = 1'b0;
  longint      seg_steps = 0;
  longint      seg_cycles = 0;
  longint      exp_steps [$];
  longint      exp_len [$];                             // Zero means length not checked
  logic        exp_dir [$];
  longint      model_acc = 0;
  longint      enc_expected = 0;
  int          quad_phase = 0;
  logic [7:0]  divisor = `CLK_DIVISOR_DEFAULT;
  logic [63:0] reply;

  motion_top DUT (
    .CLK(CLK), .resetn(resetn),
    .SCK(SCK), .CS(CS), .COPI(COPI), .CIPO(CIPO),
    .ENC_A(ENC_A), .ENC_B(ENC_B), .HALTN(HALTN),
    .STEP(STEP), .DIR(DIR), .ENABLE(ENABLE), .MOVE_DONE(MOVE_DONE),
    .BUFFER_READY(BUFFER_READY), .ENC_FAULT(ENC_FAULT)
  );

  initial begin
    forever #4 CLK = ~CLK;
  end

  // Steps are single-cycle pulses for any divisor above zero
  assert property (@(posedge CLK) disable iff (!resetn) STEP |=> !STEP)
    else begin
      other_cnt++;
      $display("STEP stayed high for two cycles at %0t", $time);
    end

  assert property (@(posedge CLK) disable iff (!resetn) !fault_allowed |-> !ENC_FAULT)
    else begin
      other_cnt++;
      $display("ENC_FAULT rose without simultaneous encoder edges at %0t", $time);
    end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
      else begin
        mismatch_cnt++;
        $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
  endtask

  task automatic abort_run(input string why);
    $display("Timeout: %s", why);
    $display("Checks failed");
    $finish;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK);
  endtask

  // Segment bookkeeping between MOVE_DONE toggles
  always @(posedge CLK) begin
    if (resetn && !mon_off) begin
      seg_cycles++;
      if (STEP) begin
        seg_steps++;
        assert (exp_dir.size() != 0)
          else begin
            other_cnt++;
            $display("STEP pulse with no segment expected at %0t", $time);
          end
        if (exp_dir.size() != 0) begin
          check_value("DIR during STEP", DIR, exp_dir[0]);
        end
      end
      if (MOVE_DONE !== prev_done) begin
        assert (exp_steps.size() != 0)
          else begin
            other_cnt++;
            $display("MOVE_DONE toggled with no segment expected at %0t", $time);
          end
        if (exp_steps.size() != 0) begin
          check_value("steps in segment", seg_steps, exp_steps[0]);
          if (exp_len[0] != 0) check_value("segment cycles", seg_cycles, exp_len[0]);
          void'(exp_steps.pop_front());
          void'(exp_len.pop_front());
          void'(exp_dir.pop_front());
        end
        seg_steps  = 0;
        seg_cycles = 0;
      end
    end
    prev_done = MOVE_DONE;
  end

  // DDA rule with the accumulator carried over from the previous segment
  function automatic longint dda_steps(input longint dur, input longint inc,
                                       input longint ii);
    longint n;
    longint ticks;
    n     = 0;
    ticks = (dur < 1) ? 1 : dur;
    for (longint t = 0; t < ticks; t++) begin
      model_acc = model_acc + inc;
      inc       = inc + ii;
      if (model_acc >= THRESHOLD) begin
        model_acc = model_acc - THRESHOLD;
        n++;
      end
    end
    return n;
  endfunction

  // Bytes go out LSB byte first and MSB first within each byte
  task automatic xfer_word(input logic [63:0] tx, output logic [63:0] rx);
    CS <= 1'b0;
    wait_cycles(HALF_SCK + 2);
    for (int i = 0; i < 8; i++) begin
      for (int b = 7; b >= 0; b--) begin
        COPI <= tx[8*i+b];
        wait_cycles(HALF_SCK);
        rx[8*i+b] = CIPO;
        SCK <= 1'b1;
        wait_cycles(HALF_SCK);
        SCK <= 1'b0;
      end
    end
    wait_cycles(HALF_SCK);
    CS <= 1'b1;
    wait_cycles(8);
  endtask

  task automatic send_move(input logic dir, input longint dur, input longint inc,
                           input longint ii, input bit accept, input bit check_len);
    logic [63:0] rx;
    xfer_word({`CMD_COORDINATED_STEP, 55'd0, dir}, rx);
    xfer_word(dur, rx);
    xfer_word(inc, rx);
    check_value("encoder snapshot reply", rx, enc_expected);
    if (accept) begin
      exp_steps.push_back(dda_steps(dur, inc, ii));
      exp_len.push_back(check_len ? dur * (longint'(divisor) + 1) : 0);
      exp_dir.push_back(dir);
    end
    xfer_word(ii, rx);
  endtask

  task automatic drive_quad(input int n, input bit fwd);
    logic [1:0] states [4] = '{2'b00, 2'b10, 2'b11, 2'b01};  // {A, B} with A leading
    for (int i = 0; i < n; i++) begin
      quad_phase = fwd ? (quad_phase + 1) % 4 : (quad_phase + 3) % 4;
      ENC_A <= states[quad_phase][1];
      ENC_B <= states[quad_phase][0];
      enc_expected = fwd ? enc_expected + 1 : enc_expected - 1;
      wait_cycles(5);
    end
  endtask

  task automatic wait_queue_size(input int size, input int limit);
    int n;
    n = 0;
    while (exp_steps.size() > size) begin
      if (n >= limit) abort_run("segments did not complete");
      n++;
      @(posedge CLK);
    end
  endtask

  task automatic wait_ready(input logic level);
    int n;
    n = 0;
    while (BUFFER_READY !== level) begin
      if (n >= 2000) abort_run("BUFFER_READY did not reach the expected level");
      n++;
      @(posedge CLK);
    end
  endtask

  task automatic wait_enable(input logic level);
    int n;
    n = 0;
    while (ENABLE !== level) begin
      if (n >= 2000) abort_run("ENABLE did not follow the enable command");
      n++;
      @(posedge CLK);
    end
  endtask

  task automatic wait_fault();
    int n;
    n = 0;
    while (ENC_FAULT !== 1'b1) begin
      if (n >= 100) abort_run("ENC_FAULT did not rise");
      n++;
      @(posedge CLK);
    end
  endtask

  initial begin
    logic done_before;
    longint dur;
    void'($urandom(32'h3f5f016c));
    resetn = 1'b0;
    SCK    = 1'b0;
    CS     = 1'b1;
    COPI   = 1'b0;
    ENC_A  = 1'b0;
    ENC_B  = 1'b0;
    HALTN  = 1'b1;
    wait_cycles(10);
    resetn <= 1'b1;
    wait_cycles(3);

    check_value("STEP after reset", STEP, 1'b0);
    check_value("MOVE_DONE after reset", MOVE_DONE, 1'b0);
    check_value("ENABLE after reset", ENABLE, 1'b0);
    check_value("BUFFER_READY after reset", BUFFER_READY, 1'b1);
    check_value("DIR after reset", DIR, 1'b0);
    check_value("CIPO after reset", CIPO, 1'b0);

    xfer_word({`CMD_API_VERSION, 56'd0}, reply);
    xfer_word({$urandom, $urandom}, reply);
    check_value("version reply", reply,
                {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH});
    xfer_word({`CMD_MOTOR_ENABLE, 55'd0, 1'b1}, reply);
    wait_enable(1'b1);
    xfer_word({`CMD_MOTOR_ENABLE, 55'd0, 1'b0}, reply);
    wait_enable(1'b0);

    // Random segments with the encoder moved before each header
    for (int k = 0; k < 6; k++) begin
      drive_quad(1 + $urandom % 12, 1'b1);
      drive_quad($urandom % 8, 1'b0);
      send_move($urandom % 2, 1 + $urandom % 20, longint'($urandom) * 2,
                longint'($urandom % 32'h0400_0000) - 64'sh200_0000, 1'b1, 1'b0);
    end
    wait_queue_size(0, 2000);

    divisor = 8'd7;
    xfer_word({`CMD_CLK_DIVISOR, 48'd0, divisor}, reply);
    send_move(1'b0, 2500, 64'sh8000_0000, 0, 1'b1, 1'b0);   // Long one keeps the queue full
    for (int k = 0; k < `MOVE_BUFFER_DEPTH; k++) begin
      dur = 5 + $urandom % 30;
      send_move($urandom % 2, dur, longint'($urandom), 64'sh10_0000, 1'b1, 1'b1);
    end
    check_value("BUFFER_READY with no credits", BUFFER_READY, 1'b0);
    send_move(1'b1, 10, 64'sh1_0000_0000, 0, 1'b0, 1'b0);   // Dropped for lack of credit
    wait_queue_size(`MOVE_BUFFER_DEPTH, 30000);
    wait_ready(1'b1);
    wait_queue_size(0, 10000);

    // Fill every slot behind a long segment so halt has credits to restore
    send_move(1'b1, 2500, 64'sh8000_0000, 0, 1'b1, 1'b0);
    for (int k = 0; k < `MOVE_BUFFER_DEPTH; k++) begin
      send_move(k % 2, 20, 64'sh8000_0000, 0, 1'b1, 1'b0);
    end
    check_value("BUFFER_READY before halt", BUFFER_READY, 1'b0);
    done_before = MOVE_DONE;
    mon_off = 1'b1;
    HALTN <= 1'b0;
    wait_cycles(3);
    HALTN <= 1'b1;
    wait_cycles(5);
    exp_steps.delete();
    exp_len.delete();
    exp_dir.delete();
    model_acc  = 0;
    seg_steps  = 0;
    seg_cycles = 0;
    mon_off    = 1'b0;
    check_value("BUFFER_READY after halt", BUFFER_READY, 1'b1);
    for (int k = 0; k < 400; k++) begin
      @(posedge CLK);
      check_value("MOVE_DONE after halt", MOVE_DONE, done_before);
    end

    fault_allowed = 1'b1;
    wait_cycles(3);
    ENC_A <= ~ENC_A;
    ENC_B <= ~ENC_B;
    wait_fault();

    wait_cycles(20);
    $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt + other_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+hdl
hdl/host_pkg.sv
hdl/motion_pkg.sv
hdl/spi_word_rx.sv
hdl/command_decoder.sv
hdl/move_buffer.sv
hdl/dda_step_gen.sv
hdl/quad_encoder.sv
hdl/motion_top.sv
tb/motion_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= motion_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
